// File: Makefile
VERILATOR  = verilator
TOP        = tb_cpu_frontend
FILELIST   = sources.f
BUILD_DIR  = obj_dir
LOG        = sim.log
VFLAGS     = --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir $(BUILD_DIR)
LINT_FLAGS = --lint-only --timing -Wall --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Test passed$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: source/branch_predict.sv
`timescale 1ns/1ns

module branch_predict
    import cpu_config_pkg::*;
    import rv_inst_pkg::*;
(
    input  logic            clk_in,
    input  logic            reset,
    input  logic            rdy_in,
    queue_if.predictor      pq,
    output logic            redirect,
    output logic [xlen-1:0] redirect_pc,
    input  logic            issue_ready,
    input  logic            bht_update,
    input  logic [xlen-1:0] bht_update_pc,
    input  logic            bht_update_taken,
    output logic            inst_valid,
    output logic [xlen-1:0] inst_out,
    output logic [xlen-1:0] inst_pc,
    output logic [xlen-1:0] inst_next_pc
);

    logic [1:0]                 bht [bht_entries];
    inst_word_u                 head_word;
    logic [xlen-1:0]            j_imm;
    logic [xlen-1:0]            b_imm;
    logic [xlen-1:0]            seq_pc;
    logic [xlen-1:0]            pred_pc;
    logic [bht_index_width-1:0] head_idx;
    logic [bht_index_width-1:0] upd_idx;
    logic [1:0]                 upd_cnt;

    assign head_word.raw = pq.head_inst;

    assign j_imm = {{11{head_word.j.imm20}}, head_word.j.imm20, head_word.j.imm19_12,
                    head_word.j.imm11, head_word.j.imm10_1, 1'b0};
    assign b_imm = {{19{head_word.b.imm12}}, head_word.b.imm12, head_word.b.imm11,
                    head_word.b.imm10_5, head_word.b.imm4_1, 1'b0};

    assign seq_pc   = pq.head_pc + xlen'(4);
    assign head_idx = pq.head_pc[bht_index_width+1:2];

    always_comb begin
        pred_pc = seq_pc;
        if (head_word.j.opcode == op_jal) begin
            pred_pc = pq.head_pc + j_imm;
        end else if (head_word.b.opcode == op_branch && bht[head_idx][1]) begin
            pred_pc = pq.head_pc + b_imm;
        end
    end

    // pop into an empty or draining issue slot
    assign pq.pop      = rdy_in && !pq.empty && (!inst_valid || issue_ready);
    assign redirect    = pq.pop && pred_pc != seq_pc;
    assign redirect_pc = pred_pc;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            inst_valid <= 1'b0;
        end else if (rdy_in) begin
            if (pq.pop) begin
                inst_valid <= 1'b1;
            end else if (issue_ready) begin
                inst_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (rdy_in && pq.pop) begin
            inst_out     <= pq.head_inst;
            inst_pc      <= pq.head_pc;
            inst_next_pc <= pred_pc;
        end
    end

    // two-bit saturating counters
    assign upd_idx = bht_update_pc[bht_index_width+1:2];
    assign upd_cnt = bht[upd_idx];

    always_ff @(posedge clk_in) begin
        if (reset) begin
            for (int i = 0; i < bht_entries; i++) begin
                bht[i] <= bht_reset_state;
            end
        end else if (rdy_in && bht_update) begin
            if (bht_update_taken && upd_cnt != 2'b11) begin
                bht[upd_idx] <= upd_cnt + 2'b01;
            end else if (!bht_update_taken && upd_cnt != 2'b00) begin
                bht[upd_idx] <= upd_cnt - 2'b01;
            end
        end
    end

    // redirect flushes the queue and lasts one cycle
    a_redirect_pulse: assert property (
        @(posedge clk_in) disable iff (reset)
        redirect |=> pq.empty && !redirect
    ) else $error("redirect did not flush the queue for a single cycle");

endmodule

// File: source/cpu_config_pkg.sv
package cpu_config_pkg;

    // 128 KB byte-addressed memory
    localparam int addr_width = 17;

    // instruction and pc width
    localparam int xlen = 32;

    // instruction queue
    localparam int queue_depth       = 8;
    localparam int queue_ptr_width   = 3;
    localparam int queue_count_width = queue_ptr_width + 1;

    // branch history table, indexed by pc[7:2]
    localparam int bht_entries     = 64;
    localparam int bht_index_width = 6;

    localparam logic [xlen-1:0] reset_pc = '0;

    // weakly not taken
    localparam logic [1:0] bht_reset_state = 2'b01;

endpackage

// File: source/cpu_frontend.sv
`timescale 1ns/1ns

module cpu_frontend
    import cpu_config_pkg::*;
(
    input  logic            clk_in,
    input  logic            reset,
    input  logic            rdy_in,
    input  logic [7:0]      mem_din,
    output logic [31:0]     mem_a,
    input  logic            issue_ready,
    input  logic            bht_update,
    input  logic [xlen-1:0] bht_update_pc,
    input  logic            bht_update_taken,
    output logic            inst_valid,
    output logic [xlen-1:0] inst_out,
    output logic [xlen-1:0] inst_pc,
    output logic [xlen-1:0] inst_next_pc
);

    logic            redirect;
    logic [xlen-1:0] redirect_pc;

    fetch_if fq_bus ();
    queue_if pq_bus ();

    mem_fetch u_mem_fetch (
        .clk_in      (clk_in),
        .reset       (reset),
        .rdy_in      (rdy_in),
        .mem_din     (mem_din),
        .mem_a       (mem_a),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .fq          (fq_bus.producer)
    );

    // redirect doubles as the queue flush
    inst_queue u_inst_queue (
        .clk_in (clk_in),
        .reset  (reset),
        .rdy_in (rdy_in),
        .flush  (redirect),
        .fq     (fq_bus.queue),
        .pq     (pq_bus.queue)
    );

    branch_predict u_branch_predict (
        .clk_in           (clk_in),
        .reset            (reset),
        .rdy_in           (rdy_in),
        .pq               (pq_bus.predictor),
        .redirect         (redirect),
        .redirect_pc      (redirect_pc),
        .issue_ready      (issue_ready),
        .bht_update       (bht_update),
        .bht_update_pc    (bht_update_pc),
        .bht_update_taken (bht_update_taken),
        .inst_valid       (inst_valid),
        .inst_out         (inst_out),
        .inst_pc          (inst_pc),
        .inst_next_pc     (inst_next_pc)
    );

endmodule

// File: source/frontend_ifs.sv
`timescale 1ns/1ns

// fetch unit to instruction queue
interface fetch_if
    import cpu_config_pkg::*;
();

    logic            push;
    logic [xlen-1:0] push_pc;
    logic [xlen-1:0] push_inst;
    logic            full;

    modport producer (output push, output push_pc, output push_inst, input full);
    modport queue    (input push, input push_pc, input push_inst, output full);

endinterface

// instruction queue head to predictor
interface queue_if
    import cpu_config_pkg::*;
();

    logic            empty;
    logic [xlen-1:0] head_pc;
    logic [xlen-1:0] head_inst;
    logic            pop;

    modport queue     (output empty, output head_pc, output head_inst, input pop);
    modport predictor (input empty, input head_pc, input head_inst, output pop);

endinterface

// File: source/inst_queue.sv
`timescale 1ns/1ns

module inst_queue
    import cpu_config_pkg::*;
(
    input  logic   clk_in,
    input  logic   reset,
    input  logic   rdy_in,
    input  logic   flush,
    fetch_if.queue fq,
    queue_if.queue pq
);

    logic [xlen-1:0]              pc_mem   [queue_depth];
    logic [xlen-1:0]              inst_mem [queue_depth];
    logic [queue_ptr_width-1:0]   rd_ptr;
    logic [queue_ptr_width-1:0]   wr_ptr;
    logic [queue_count_width-1:0] count;

    assign fq.full      = count == queue_count_width'(queue_depth);
    assign pq.empty     = count == '0;
    assign pq.head_pc   = pc_mem[rd_ptr];
    assign pq.head_inst = inst_mem[rd_ptr];

    always_ff @(posedge clk_in) begin
        if (rdy_in && fq.push) begin
            pc_mem[wr_ptr]   <= fq.push_pc;
            inst_mem[wr_ptr] <= fq.push_inst;
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (rdy_in) begin
            if (flush) begin
                // wins over a push in the same cycle
                rd_ptr <= '0;
                wr_ptr <= '0;
                count  <= '0;
            end else begin
                if (fq.push) begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
                if (pq.pop) begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
                case ({fq.push, pq.pop})
                    2'b10:   count <= count + 1'b1;
                    2'b01:   count <= count - 1'b1;
                    default: count <= count;
                endcase
            end
        end
    end

    a_no_pop_when_empty: assert property (
        @(posedge clk_in) disable iff (reset)
        pq.pop |-> !pq.empty
    ) else $error("predictor popped an empty queue");

    a_count_in_range: assert property (
        @(posedge clk_in) disable iff (reset)
        count <= queue_count_width'(queue_depth)
    ) else $error("queue count above depth");

endmodule

// File: source/mem_fetch.sv
`timescale 1ns/1ns

module mem_fetch
    import cpu_config_pkg::*;
(
    input  logic            clk_in,
    input  logic            reset,
    input  logic            rdy_in,
    input  logic [7:0]      mem_din,
    output logic [31:0]     mem_a,
    input  logic            redirect,
    input  logic [xlen-1:0] redirect_pc,
    fetch_if.producer       fq
);

    logic [xlen-1:0] fetch_pc;
    logic [2:0]      byte_cnt;
    logic [23:0]     byte_sr;
    logic [2:0]      addr_ofs;
    logic [xlen-1:0] bus_addr;

    // byte_cnt 0..3 drives pc+n, the byte for pc+n-1 comes back meanwhile
    // byte_cnt 4 only receives the last byte

    // while frozen, keep the address whose byte is still awaited
    assign addr_ofs = (!rdy_in && byte_cnt != 3'd0) ? byte_cnt - 3'd1 : byte_cnt;
    assign bus_addr = fetch_pc + xlen'(addr_ofs);
    assign mem_a    = {{(32 - addr_width){1'b0}}, bus_addr[addr_width-1:0]};

    // little endian, last byte straight from the bus
    assign fq.push      = rdy_in && byte_cnt == 3'd4;
    assign fq.push_pc   = fetch_pc;
    assign fq.push_inst = {mem_din, byte_sr};

    always_ff @(posedge clk_in) begin
        if (reset) begin
            fetch_pc <= reset_pc;
            byte_cnt <= 3'd0;
        end else if (rdy_in) begin
            if (redirect) begin
                // partial word is dropped
                fetch_pc <= redirect_pc;
                byte_cnt <= 3'd0;
            end else begin
                case (byte_cnt)
                    3'd0: begin
                        // a word only starts with room in the queue
                        if (!fq.full) begin
                            byte_cnt <= 3'd1;
                        end
                    end
                    3'd1, 3'd2, 3'd3: begin
                        byte_cnt <= byte_cnt + 3'd1;
                    end
                    3'd4: begin
                        fetch_pc <= fetch_pc + xlen'(4);
                        byte_cnt <= 3'd0;
                    end
                    default: begin
                        byte_cnt <= 3'd0;
                    end
                endcase
            end
        end
    end

    // bytes 0..2 gathered low to high
    always_ff @(posedge clk_in) begin
        if (rdy_in && byte_cnt != 3'd0) begin
            byte_sr <= {mem_din, byte_sr[23:8]};
        end
    end

    // one word in flight must always find space
    a_no_push_when_full: assert property (
        @(posedge clk_in) disable iff (reset)
        fq.push |-> !fq.full
    ) else $error("fetch pushed a word into a full queue");

endmodule

// File: source/rv_inst_pkg.sv
package rv_inst_pkg;

    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_branch = 7'b1100011;

    // B-type layout
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fields_t;

    // J-type layout, immediate bits are scattered
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fields_t;

    // one fetched word, seen raw or through either immediate layout
    typedef union packed {
        logic [31:0] raw;
        b_fields_t   b;
        j_fields_t   j;
    } inst_word_u;

endpackage

// File: sources.f
source/cpu_config_pkg.sv
source/rv_inst_pkg.sv
source/frontend_ifs.sv
source/mem_fetch.sv
source/inst_queue.sv
source/branch_predict.sv
source/cpu_frontend.sv
tb/tb_cpu_frontend.sv

// File: tb/fetch_patterns.txt
// memory words by word index (byte address / 4), then at @10 the trace length
// and training point, then from @20 the expected issued pc and next pc pairs
@00
00108093  // 0x00 addi x1, x1, 1
00000e63  // 0x04 beq x0, x0, 0x20
ff9ff06f  // 0x08 jal x0, 0x00
00210113 00318193 00420213 00528293 00630313  // 0x0c .. 0x1c alu filler
0000006f  // 0x20 jal x0, 0x20
00738393 00840413 00948493 00a50513  // 0x24 .. 0x30 alu filler
00b58593 00c60613 00d68693  // 0x34 .. 0x3c alu filler
@10
00000008  // issues checked
00000003  // counter trained after this many issues
@20
00000000 00000004
00000004 00000008
00000008 00000000
00000000 00000004
00000004 00000020
00000020 00000020
00000020 00000020
00000020 00000020

// File: tb/tb_cpu_frontend.sv
`timescale 1ns/1ns

module tb_cpu_frontend
    import cpu_config_pkg::*;
    import rv_inst_pkg::*;
();

    localparam int          wait_limit = 400;
    localparam logic [31:0] branch_pc  = 32'h4;

    logic            clk_in;
    logic            reset;
    logic            rdy_in;
    logic [7:0]      mem_din;
    logic [31:0]     mem_a;
    logic            issue_ready;
    logic            bht_update;
    logic [xlen-1:0] bht_update_pc;
    logic            bht_update_taken;
    logic            inst_valid;
    logic [xlen-1:0] inst_out;
    logic [xlen-1:0] inst_pc;
    logic [xlen-1:0] inst_next_pc;

    logic [31:0] pattern_words [0:63];
    logic [7:0]  mem_bytes [0:255];
    logic [31:0] addr_q;
    logic [31:0] exp_pc;
    logic [31:0] exp_next;
    logic [31:0] exp_word;
    logic [31:0] held_inst;
    logic [31:0] held_pc;
    logic [31:0] held_next;
    logic [31:0] last_next_pc;
    logic        last_was_jal;
    logic        timed_out;
    logic        accepted;
    int          errors;
    int          range_errors;
    int          seed;
    int          rdy_stall;
    int          ready_stall;
    int          trace_len;
    int          train_pos;
    int          timer;
    int          k;

    cpu_frontend uut (
        .clk_in           (clk_in),
        .reset            (reset),
        .rdy_in           (rdy_in),
        .mem_din          (mem_din),
        .mem_a            (mem_a),
        .issue_ready      (issue_ready),
        .bht_update       (bht_update),
        .bht_update_pc    (bht_update_pc),
        .bht_update_taken (bht_update_taken),
        .inst_valid       (inst_valid),
        .inst_out         (inst_out),
        .inst_pc          (inst_pc),
        .inst_next_pc     (inst_next_pc)
    );

    initial begin
        clk_in = 1'b0;
        forever #50 clk_in = ~clk_in;
    end

    // byte memory answers the address of the previous cycle
    always @(posedge clk_in) begin
        addr_q <= mem_a;
    end

    always @(negedge clk_in) begin
        if (addr_q > 32'd255) begin
            range_errors++;
            $display("fetch address %h lies outside the memory model", addr_q);
        end
        mem_din = mem_bytes[addr_q[7:0]];
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("** Error: %s expected %h actual %h", name, expected, actual);
        end
    endtask

    function automatic logic [31:0] word_at(input logic [31:0] addr);
        logic [7:0] base;
        base = addr[7:0];
        return {mem_bytes[base + 8'd3], mem_bytes[base + 8'd2],
                mem_bytes[base + 8'd1], mem_bytes[base]};
    endfunction

    // target from the J-type immediate
    function automatic logic [31:0] jal_target(input logic [31:0] pc, input logic [31:0] word);
        logic [31:0] offset;
        offset = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
        return pc + offset;
    endfunction

    task automatic check_held;
        check_value($sformatf("issue %0d held inst_valid", k), 32'd1, {31'd0, inst_valid});
        check_value($sformatf("issue %0d held inst_out", k), held_inst, inst_out);
        check_value($sformatf("issue %0d held inst_pc", k), held_pc, inst_pc);
        check_value($sformatf("issue %0d held inst_next_pc", k), held_next, inst_next_pc);
    endtask

    // stall stretches for rdy_in and issue_ready
    task automatic drive_random;
        if (rdy_stall == 0 && ($random(seed) & 7) == 0) begin
            rdy_stall = 1 + ($random(seed) & 3);
        end
        if (ready_stall == 0 && ($random(seed) & 3) == 0) begin
            ready_stall = 1 + ($random(seed) & 7);
        end
        rdy_in      = (rdy_stall == 0);
        issue_ready = (ready_stall == 0);
        if (rdy_stall != 0) begin
            rdy_stall--;
        end
        if (ready_stall != 0) begin
            ready_stall--;
        end
    endtask

    // two taken updates while the current issue is held
    task automatic train_counter;
        rdy_in           = 1'b1;
        issue_ready      = 1'b0;
        bht_update_pc    = branch_pc;
        bht_update_taken = 1'b1;
        bht_update       = 1'b1;
        repeat (2) begin
            @(negedge clk_in);
            check_held();
        end
        bht_update = 1'b0;
    endtask

    task automatic load_memory;
        for (int i = 0; i < 64; i++) begin
            pattern_words[i] = '0;
        end
        $readmemh("tb/fetch_patterns.txt", pattern_words);
        for (int a = 0; a < 256; a++) begin
            mem_bytes[a] = 8'(a * 37) ^ 8'h5c;
        end
        for (int w = 0; w < 16; w++) begin
            for (int b = 0; b < 4; b++) begin
                mem_bytes[4 * w + b] = pattern_words[w][8 * b +: 8];
            end
        end
        trace_len = int'(pattern_words[16]);
        train_pos = int'(pattern_words[17]);
        if (trace_len == 0 || trace_len > 16) begin
            errors++;
            $display("pattern file is missing or holds a bad trace length");
            trace_len = 0;
        end
    endtask

    initial begin
        reset            = 1'b1;
        rdy_in           = 1'b1;
        mem_din          = 8'd0;
        issue_ready      = 1'b0;
        bht_update       = 1'b0;
        bht_update_pc    = '0;
        bht_update_taken = 1'b0;
        errors           = 0;
        range_errors     = 0;
        seed             = 32'h0c5b292a;
        rdy_stall        = 0;
        ready_stall      = 0;
        timed_out        = 1'b0;
        last_was_jal     = 1'b0;
        last_next_pc     = '0;
        load_memory();

        repeat (4) @(negedge clk_in);
        check_value("reset inst_valid", 32'd0, {31'd0, inst_valid});
        check_value("reset mem_a", reset_pc, mem_a);
        reset = 1'b0;

        for (k = 0; k < trace_len && !timed_out; k++) begin
            timer = 0;
            while (!inst_valid && !timed_out) begin
                if (timer >= wait_limit) begin
                    errors++;
                    timed_out = 1'b1;
                    $display("timed out waiting for instruction %0d to issue", k);
                end else begin
                    drive_random();
                    @(negedge clk_in);
                    timer++;
                end
            end
            if (!timed_out) begin
                exp_pc   = pattern_words[32 + 2 * k];
                exp_next = pattern_words[33 + 2 * k];
                exp_word = word_at(exp_pc);
                check_value($sformatf("issue %0d inst_pc", k), exp_pc, inst_pc);
                check_value($sformatf("issue %0d inst_next_pc", k), exp_next, inst_next_pc);
                check_value($sformatf("issue %0d inst_out", k), word_at(inst_pc), inst_out);
                // a jal target is the very next issue
                if (last_was_jal) begin
                    check_value($sformatf("issue %0d after jal", k), last_next_pc, inst_pc);
                end
                last_was_jal = exp_word[6:0] == op_jal;
                if (last_was_jal) begin
                    last_next_pc = jal_target(exp_pc, exp_word);
                    check_value($sformatf("issue %0d jal target", k), last_next_pc,
                                inst_next_pc);
                end
                held_inst = exp_word;
                held_pc   = exp_pc;
                held_next = exp_next;
                if (k + 1 == train_pos) begin
                    train_counter();
                end
                accepted = 1'b0;
                timer    = 0;
                while (!accepted && !timed_out) begin
                    if (timer >= wait_limit) begin
                        errors++;
                        timed_out = 1'b1;
                        $display("timed out waiting for instruction %0d to be accepted", k);
                    end else begin
                        drive_random();
                        accepted = rdy_in && issue_ready;
                        @(negedge clk_in);
                        if (!accepted) begin
                            check_held();
                        end
                        timer++;
                    end
                end
            end
        end

        $display("check errors: %0d, memory range errors: %0d", errors, range_errors);
        if (errors == 0 && range_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
